//--- src/tileGeomPkg.sv
`default_nettype none

package tileGeomPkg;

	////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////
	localparam int hCountWidth = 9;
	localparam int vCountWidth = 9;

	// Scroll register widths
	// X spans the full 512 pixel map
	localparam int scrollXWidth = 9;
	localparam int scrollYWidth = 8;
	localparam int fineWidth = 3;

	////////////////////////////////////////
	// Address buses
	////////////////////////////////////////
	localparam int ramAddrWidth = 12;
	// Top bit picks the layer half of tile RAM
	localparam int busRamAddrWidth = 13;
	localparam int romAddrWidth = 14;

	typedef enum logic {layerA, layerB} layerSel;
	// Phase within the 8 pixel cell
	typedef enum logic [1:0] {slotCode, slotAttr, slotIdle} fetchSlot;

endpackage

`default_nettype wire

//--- src/cpuBusPkg.sv
`default_nettype none

package cpuBusPkg;

	////////////////////////////////////////
	// CPU side bus
	////////////////////////////////////////
	localparam int cpuAddrWidth = 14;
	localparam int dataWidth = 8;

	// Register select from CPU address bits 1..0
	// Bit 2 of the address picks the layer
	typedef enum logic [1:0] {
		regScrollXHi,
		regScrollXLo,
		regScrollY,
		regUnused
	} scrollReg;

	// XHi only carries bit 8 of scroll X in data bit 0
	// XLo carries bits 7..0
	// Y carries the full vertical scroll byte

endpackage

`default_nettype wire

//--- src/scrollIf.sv
`timescale 1ns/1ns
`default_nettype none

// One layer's scroll state
interface scrollIf;
	import tileGeomPkg::*;

	logic [scrollXWidth-1:0] scrollX;
	logic [scrollYWidth-1:0] scrollY;
	logic flip;
	// Single cycle pulse after a latch write to this layer
	logic loaded;

	modport regs (output scrollX, scrollY, flip, loaded);
	modport layer (input scrollX, scrollY, flip, loaded);

endinterface

`default_nettype wire

//--- src/layerFetchIf.sv
`timescale 1ns/1ns
`default_nettype none

// Layer fetch addresses out, tile RAM byte back
interface layerFetchIf;
	import tileGeomPkg::*;
	import cpuBusPkg::*;

	logic [ramAddrWidth-1:0] ramAddr;
	logic [romAddrWidth-1:0] romAddr;
	logic [fineWidth-1:0] fineH;
	// Tile byte while this layer owns the RAM bus
	logic [dataWidth-1:0] ramData;

	modport layer (output ramAddr, romAddr, fineH, input ramData);
	modport mux (input ramAddr, romAddr, fineH, output ramData);

endinterface

`default_nettype wire

//--- src/scrollRegs.sv
`timescale 1ns/1ns
`default_nettype none

module scrollRegs (
	input logic CLK_6M,
	input logic reset,
	input logic latchN,
	input logic flip,
	input logic [2:0] cpuAddr,
	input logic [cpuBusPkg::dataWidth-1:0] cpuData,
	scrollIf.regs scrollA,
	scrollIf.regs scrollB
);
	import tileGeomPkg::*;
	import cpuBusPkg::*;

	// Indexed by layer
	logic [scrollXWidth-1:0] scrollX [2];
	logic [scrollYWidth-1:0] scrollY [2];
	logic loaded [2];
	logic flipReg;

	layerSel wrLayer;
	scrollReg regSel;

	// Address decode
	assign wrLayer = layerSel'(cpuAddr[2]);
	assign regSel = scrollReg'(cpuAddr[1:0]);

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////
	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			scrollX <= '{default: '0};
			scrollY <= '{default: '0};
			loaded <= '{default: 1'b0};
			flipReg <= 1'b0;
		end else begin
			// Default no pulse
			loaded <= '{default: 1'b0};
			flipReg <= flip;
			if (!latchN) begin
				loaded[wrLayer] <= 1'b1;
				case (regSel)
					regScrollXHi: scrollX[wrLayer][scrollXWidth-1] <= cpuData[0];
					regScrollXLo: scrollX[wrLayer][scrollXWidth-2:0] <= cpuData;
					regScrollY: scrollY[wrLayer] <= cpuData;
					default: ;
				endcase
			end
		end
	end

	// Out to the layers
	assign scrollA.scrollX = scrollX[layerA];
	assign scrollA.scrollY = scrollY[layerA];
	assign scrollA.loaded = loaded[layerA];
	assign scrollA.flip = flipReg;

	assign scrollB.scrollX = scrollX[layerB];
	assign scrollB.scrollY = scrollY[layerB];
	assign scrollB.loaded = loaded[layerB];
	assign scrollB.flip = flipReg;

endmodule

`default_nettype wire

//--- src/layerAddrGen.sv
`timescale 1ns/1ns
`default_nettype none

module layerAddrGen (
	input logic CLK_6M,
	input logic reset,
	input logic hSyncN,
	input logic vSyncN,
	scrollIf.layer scroll,
	layerFetchIf.layer fetch
);
	import tileGeomPkg::*;
	import cpuBusPkg::*;

	logic [hCountWidth-1:0] hCount;
	logic [vCountWidth-1:0] vCount;
	logic hSyncPrev;
	logic hSyncFall;

	// Counts after flip
	logic [hCountWidth-1:0] hEff;
	logic [vCountWidth-1:0] vEff;
	logic [scrollXWidth-1:0] scrolledX;
	logic [vCountWidth-1:0] scrolledY;

	fetchSlot slot;
	logic byteSel;
	logic [dataWidth-1:0] tileCode;
	logic [1:0] tileAttr;
	logic [fineWidth-1:0] fineReg;

	////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////
	assign hSyncFall = hSyncPrev & ~hSyncN;

	always_ff @(posedge CLK_6M) begin
		if (reset) begin
			hCount <= '0;
			vCount <= '0;
			hSyncPrev <= 1'b1;
		end else begin
			hSyncPrev <= hSyncN;
			// Held at zero through the sync pulse
			if (!hSyncN)
				hCount <= '0;
			else
				hCount <= hCount + 1'b1;
			// One line per hsync falling edge
			if (!vSyncN)
				vCount <= '0;
			else if (hSyncFall)
				vCount <= vCount + 1'b1;
		end
	end

	// Flipped screen runs the counts backwards
	assign hEff = scroll.flip ? ~hCount : hCount;
	assign vEff = scroll.flip ? ~vCount : vCount;
	assign scrolledX = hEff + scroll.scrollX;
	assign scrolledY = vEff + vCountWidth'(scroll.scrollY);

	////////////////////////////////////////
	// Tile fetch
	////////////////////////////////////////
	always_comb begin
		case (scrolledX[2:0])
			3'd0: slot = slotCode;
			3'd1: slot = slotAttr;
			default: slot = slotIdle;
		endcase
	end

	// Code byte even, attribute byte odd
	assign byteSel = (slot == slotAttr);
	assign fetch.ramAddr = {scrolledY[7:3], scrolledX[8:3], byteSel};

	// Tile bytes latched at the end of their slot
	always_ff @(posedge CLK_6M) begin
		if (slot == slotCode)
			tileCode <= fetch.ramData;
		if (slot == slotAttr)
			tileAttr <= fetch.ramData[1:0];
	end

	// Bank bits, code, row in tile, half of tile
	assign fetch.romAddr = {tileAttr, tileCode, scrolledY[2:0], scrolledX[2]};

	// Fine scroll follows each register write
	always_ff @(posedge CLK_6M) begin
		if (reset)
			fineReg <= '0;
		else if (scroll.loaded)
			fineReg <= scroll.scrollX[2:0];
	end

	assign fetch.fineH = fineReg;

endmodule

`default_nettype wire

//--- src/busMux.sv
`timescale 1ns/1ns
`default_nettype none

module busMux (
	input logic CLK_6M,
	input logic reset,
	input logic clk2H,
	input logic ramCsN,
	input logic readNotWrite,
	input logic [cpuBusPkg::cpuAddrWidth-1:0] cpuAddr,
	input logic [cpuBusPkg::dataWidth-1:0] cpuDataIn,
	input logic [cpuBusPkg::dataWidth-1:0] ramDataIn,
	layerFetchIf.mux fetchA,
	layerFetchIf.mux fetchB,
	output logic [tileGeomPkg::busRamAddrWidth-1:0] ramAddr,
	output logic [tileGeomPkg::romAddrWidth-1:0] romAddr,
	output logic ramWeN,
	output logic ramOeN,
	output logic [cpuBusPkg::dataWidth-1:0] cpuDataOut,
	output logic cpuDataOe,
	output logic [cpuBusPkg::dataWidth-1:0] ramDataOut,
	output logic ramDataOe
);
	import tileGeomPkg::*;

	// 2H low is layer A, high is layer B
	layerSel phase;
	logic rnwPrev;

	assign phase = layerSel'(clk2H);

	////////////////////////////////////////
	// Address multiplexing
	////////////////////////////////////////
	// CPU wins the RAM bus
	assign ramAddr = !ramCsN ? cpuAddr[busRamAddrWidth-1:0]
		: {~clk2H, (phase == layerB) ? fetchB.ramAddr : fetchA.ramAddr};
	assign romAddr = (phase == layerB) ? fetchB.romAddr : fetchA.romAddr;

	// Both layers see the same RAM data
	assign fetchA.ramData = ramDataIn;
	assign fetchB.ramData = ramDataIn;

	////////////////////////////////////////
	// RAM strobes and data steering
	////////////////////////////////////////
	always_ff @(posedge CLK_6M) begin
		if (reset)
			rnwPrev <= 1'b1;
		else
			rnwPrev <= readNotWrite;
	end

	// Write pulse only on the first write cycle
	assign ramWeN = ramCsN | readNotWrite | ~rnwPrev;
	assign ramOeN = ramCsN | ~readNotWrite;

	// CPU read
	assign cpuDataOe = ~ramCsN & readNotWrite;
	assign cpuDataOut = ramDataIn;
	// CPU write
	assign ramDataOe = ~ramCsN & ~readNotWrite;
	assign ramDataOut = cpuDataIn;

endmodule

`default_nettype wire

//--- src/tilemapAddrGen.sv
`timescale 1ns/1ns
`default_nettype none

module tilemapAddrGen (
	input logic CLK_6M,
	input logic reset,
	input logic clk2H,
	input logic hSyncN,
	input logic vSyncN,
	input logic latchN,
	input logic ramCsN,
	input logic flip,
	input logic [cpuBusPkg::cpuAddrWidth-1:0] cpuAddr,
	input logic readNotWrite,
	input logic [cpuBusPkg::dataWidth-1:0] cpuDataIn,
	input logic [cpuBusPkg::dataWidth-1:0] ramDataIn,
	output logic [cpuBusPkg::dataWidth-1:0] cpuDataOut,
	output logic cpuDataOe,
	output logic [cpuBusPkg::dataWidth-1:0] ramDataOut,
	output logic ramDataOe,
	output logic [tileGeomPkg::busRamAddrWidth-1:0] ramAddr,
	output logic [tileGeomPkg::romAddrWidth-1:0] romAddr,
	output logic ramWeN,
	output logic ramOeN,
	output logic [tileGeomPkg::fineWidth-1:0] fineHA,
	output logic [tileGeomPkg::fineWidth-1:0] fineHB
);

	scrollIf scrollA ();
	scrollIf scrollB ();
	layerFetchIf fetchA ();
	layerFetchIf fetchB ();

	////////////////////////////////////////
	// CPU scroll registers
	////////////////////////////////////////
	scrollRegs u_scrollRegs (
		.CLK_6M(CLK_6M),
		.reset(reset),
		.latchN(latchN),
		.flip(flip),
		.cpuAddr(cpuAddr[2:0]),
		.cpuData(cpuDataIn),
		.scrollA(scrollA.regs),
		.scrollB(scrollB.regs)
	);

	// Two identical layers
	layerAddrGen layerA (
		.CLK_6M(CLK_6M),
		.reset(reset),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.scroll(scrollA.layer),
		.fetch(fetchA.layer)
	);

	layerAddrGen layerB (
		.CLK_6M(CLK_6M),
		.reset(reset),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.scroll(scrollB.layer),
		.fetch(fetchB.layer)
	);

	////////////////////////////////////////
	// Shared RAM and ROM buses
	////////////////////////////////////////
	busMux u_busMux (
		.CLK_6M(CLK_6M),
		.reset(reset),
		.clk2H(clk2H),
		.ramCsN(ramCsN),
		.readNotWrite(readNotWrite),
		.cpuAddr(cpuAddr),
		.cpuDataIn(cpuDataIn),
		.ramDataIn(ramDataIn),
		.fetchA(fetchA.mux),
		.fetchB(fetchB.mux),
		.ramAddr(ramAddr),
		.romAddr(romAddr),
		.ramWeN(ramWeN),
		.ramOeN(ramOeN),
		.cpuDataOut(cpuDataOut),
		.cpuDataOe(cpuDataOe),
		.ramDataOut(ramDataOut),
		.ramDataOe(ramDataOe)
	);

	// Fine scroll straight to the pixel shifters
	assign fineHA = fetchA.fineH;
	assign fineHB = fetchB.fineH;

endmodule

`default_nettype wire

//--- testbench/tbTilemapAddrGen.sv
`timescale 1ns/1ns
`default_nettype none

module tbTilemapAddrGen;
	import tileGeomPkg::*;
	import cpuBusPkg::*;

	localparam int maxLines = 200;
	localparam int maxRepeat = 64;
	// Count, ten inputs, ten expected outputs, mask
	localparam int fieldCount = 22;

	logic CLK_6M;
	logic reset;
	logic clk2H;
	logic hSyncN;
	logic vSyncN;
	logic latchN;
	logic ramCsN;
	logic flip;
	logic [cpuAddrWidth-1:0] cpuAddr;
	logic readNotWrite;
	logic [dataWidth-1:0] cpuDataIn;
	logic [dataWidth-1:0] ramDataIn;
	logic [dataWidth-1:0] cpuDataOut;
	logic cpuDataOe;
	logic [dataWidth-1:0] ramDataOut;
	logic ramDataOe;
	logic [busRamAddrWidth-1:0] ramAddr;
	logic [romAddrWidth-1:0] romAddr;
	logic ramWeN;
	logic ramOeN;
	logic [fineWidth-1:0] fineHA;
	logic [fineWidth-1:0] fineHB;

	// Fields of the current vector line
	int unsigned f [fieldCount];
	int fd;
	int code;
	int lineNo;
	string line;

	tilemapAddrGen u_dut (
		.CLK_6M(CLK_6M),
		.reset(reset),
		.clk2H(clk2H),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.latchN(latchN),
		.ramCsN(ramCsN),
		.flip(flip),
		.cpuAddr(cpuAddr),
		.readNotWrite(readNotWrite),
		.cpuDataIn(cpuDataIn),
		.ramDataIn(ramDataIn),
		.cpuDataOut(cpuDataOut),
		.cpuDataOe(cpuDataOe),
		.ramDataOut(ramDataOut),
		.ramDataOe(ramDataOe),
		.ramAddr(ramAddr),
		.romAddr(romAddr),
		.ramWeN(ramWeN),
		.ramOeN(ramOeN),
		.fineHA(fineHA),
		.fineHB(fineHB)
	);

	// 20 ns pixel clock
	always #10 CLK_6M = ~CLK_6M;

	task automatic abortRun();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h, expected %h", name, actual, expected);
			abortRun();
		end
	endtask

	////////////////////////////////////////
	// Vector handling
	////////////////////////////////////////
	task automatic driveInputs();
		clk2H = f[1][0];
		hSyncN = f[2][0];
		vSyncN = f[3][0];
		latchN = f[4][0];
		ramCsN = f[5][0];
		flip = f[6][0];
		cpuAddr = f[7][cpuAddrWidth-1:0];
		readNotWrite = f[8][0];
		cpuDataIn = f[9][dataWidth-1:0];
		// Values above a byte mean any data will do
		if (f[10] > 32'hff)
			ramDataIn = 8'($urandom);
		else
			ramDataIn = f[10][dataWidth-1:0];
	endtask

	// Mask bit 9 is the first expected column
	task automatic checkOutputs(input int unsigned mask);
		if (mask[9])
			checkValue("cpuDataOut", 32'(cpuDataOut), f[11]);
		if (mask[8])
			checkValue("cpuDataOe", 32'(cpuDataOe), f[12]);
		if (mask[7])
			checkValue("ramDataOut", 32'(ramDataOut), f[13]);
		if (mask[6])
			checkValue("ramDataOe", 32'(ramDataOe), f[14]);
		if (mask[5])
			checkValue("ramAddr", 32'(ramAddr), f[15]);
		if (mask[4])
			checkValue("romAddr", 32'(romAddr), f[16]);
		if (mask[3])
			checkValue("ramWeN", 32'(ramWeN), f[17]);
		if (mask[2])
			checkValue("ramOeN", 32'(ramOeN), f[18]);
		if (mask[1])
			checkValue("fineHA", 32'(fineHA), f[19]);
		if (mask[0])
			checkValue("fineHB", 32'(fineHB), f[20]);
	endtask

	// Held for count cycles and checked before the last rising edge
	task automatic runVector();
		int unsigned count;
		count = f[0];
		if (count == 0 || count > maxRepeat) begin
			$display("vector line %0d has a bad repeat count %0d", lineNo, count);
			abortRun();
		end
		for (int i = 0; i < count; i++) begin
			driveInputs();
			#1;
			if (i == count - 1)
				checkOutputs(f[21]);
			@(negedge CLK_6M);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////
	initial begin
		CLK_6M = 1'b0;
		reset = 1'b1;
		clk2H = 1'b0;
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		latchN = 1'b1;
		ramCsN = 1'b1;
		flip = 1'b0;
		cpuAddr = '0;
		readNotWrite = 1'b1;
		cpuDataIn = '0;
		ramDataIn = '0;
		void'($urandom(47));
		fd = $fopen("testbench/vectorsInput.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file");
			abortRun();
		end
		repeat (5) @(negedge CLK_6M);
		reset = 1'b0;
		lineNo = 0;
		while (!$feof(fd)) begin
			lineNo++;
			if (lineNo > maxLines) begin
				$display("vector file did not finish within %0d lines", maxLines);
				abortRun();
			end
			code = $fgets(line, fd);
			// Blank lines and comments
			if (code <= 0 || line.len() < 2)
				continue;
			if (line.substr(0, 1) == "//")
				continue;
			code = $sscanf(line,
				"%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
				f[21]);
			if (code != fieldCount) begin
				$display("vector line %0d is malformed", lineNo);
				abortRun();
			end
			runVector();
		end
		$fclose(fd);
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/vectorsInput.txt
// cnt 2H hs vs latch cs flip addr rnw din rdin cpuOut cpuOe ramOut ramOe ramAddr romAddr weN oeN fineA fineB mask
// rdin 100 is a random byte, mask bits 9..0 select expected columns cpuOut..fineB
// Reset state
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1000 0000 1 1 0 0 16f
// CPU read, then a two cycle write
1 0 1 1 1 0 0 1234 1 00 05a  5a 1 00 0 1234 0000 1 0 0 0 36c
1 0 1 1 1 0 0 0abc 0 c3 100  00 0 c3 1 0abc 0000 0 1 0 0 1ec
1 0 1 1 1 0 0 0abc 0 c3 100  00 0 c3 1 0abc 0000 1 1 0 0 1ec
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 0000 0000 1 1 0 0 14c
// Sync pulse, line starts at cell zero
2 0 0 0 1 1 0 0000 1 00 100  00 0 00 0 1000 0000 1 1 0 0 02b
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1000 0000 1 1 0 0 02b
// Scroll writes A XLo=0b, B XLo=15, B XHi=1, A Y=11
1 0 1 1 0 1 0 0001 1 0b 100  00 0 00 0 1001 0000 1 1 0 0 023
1 0 1 1 0 1 0 0005 1 15 100  00 0 00 0 0000 0000 1 1 0 0 003
1 0 1 1 0 1 0 0004 1 01 100  00 0 00 0 0000 0000 1 1 3 0 003
1 0 1 1 0 1 0 0002 1 11 100  00 0 00 0 0000 0000 1 1 3 5 003
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 0000 0000 1 1 3 5 003
1 0 0 0 1 1 0 0000 1 00 100  00 0 00 0 0000 0000 1 1 3 5 003
// Scrolled line, 2H picks the layer, tile bytes fed in their slots
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1102 0000 1 1 0 0 020
1 1 1 1 1 1 0 0000 1 00 100  00 0 00 0 0044 0000 1 1 0 0 020
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1102 0000 1 1 0 0 020
1 1 1 1 1 1 0 0000 1 00 04d  00 0 00 0 0046 0000 1 1 0 0 020
1 1 1 1 1 1 0 0000 1 00 002  00 0 00 0 0047 0000 1 1 0 0 020
1 0 1 1 1 1 0 0000 1 00 07e  00 0 00 0 1104 0000 1 1 0 0 020
1 0 1 1 1 1 0 0000 1 00 003  00 0 00 0 1105 0000 1 1 0 0 020
1 1 1 1 1 1 0 0000 1 00 100  00 0 00 0 0046 24d1 1 1 0 0 030
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1104 37e2 1 1 0 0 030
1 1 1 1 1 1 0 0000 1 00 100  00 0 00 0 0046 24d1 1 1 0 0 030
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 1104 37e3 1 1 0 0 030
// Flipped screen from the next line start
1 0 0 0 1 1 1 0000 1 00 100  00 0 00 0 0000 0000 1 1 3 5 003
1 0 1 1 1 1 1 0000 1 00 100  00 0 00 0 1102 0000 1 1 0 0 020
1 0 1 1 1 1 1 0000 1 00 001  00 0 00 0 1103 0000 1 1 0 0 020
1 1 1 1 1 1 1 0000 1 00 0a5  00 0 00 0 0fc4 0000 1 1 0 0 020
1 1 1 1 1 1 1 0000 1 00 000  00 0 00 0 0fc5 0000 1 1 0 0 020
1 0 1 1 1 1 1 0000 1 00 03c  00 0 00 0 1100 1a51 1 1 0 0 030
1 1 1 1 1 1 1 0000 1 00 100  00 0 00 0 0fc2 03cf 1 1 0 0 030
// Idle
1 0 1 1 1 1 0 0000 1 00 100  00 0 00 0 0000 0000 1 1 3 5 00f

//--- verilog.f
src/tileGeomPkg.sv
src/cpuBusPkg.sv
src/scrollIf.sv
src/layerFetchIf.sv
src/scrollRegs.sv
src/layerAddrGen.sv
src/busMux.sv
src/tilemapAddrGen.sv
testbench/tbTilemapAddrGen.sv

//--- Makefile
TOP = tbTilemapAddrGen

.PHONY: all lint clean

# Build, run, then look for the pass line in the log
all: obj_dir/V$(TOP)
	-obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

obj_dir/V$(TOP): verilog.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)
	verilator --binary --timing --top-module $(TOP) -f verilog.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f verilog.f

clean:
	rm -rf obj_dir sim.log
